/* design/fpga_defs.svh */
`ifndef FPGA_DEFS_SVH
`define FPGA_DEFS_SVH

// CPU bus
`define CPU_ADDR_BITS 17
`define BUS_ADDR_BITS 14  // Word address
`define BUS_DATA_BITS 16

// Modulation memory
`define MOD_ADDR_BITS 9  // 512 words per segment
`define MOD_IDX_BITS (`MOD_ADDR_BITS + 1)  // Two samples per word
`define MOD_SAMPLE_BITS 8
`define FREQ_DIV_BITS 16

// STM memory
`define STM_ADDR_BITS 10  // Words per page
`define STM_PAGE_BITS 2

// Register defaults
`define MOD_FREQ_DIV_DEFAULT 10
`define MOD_CYCLE_DEFAULT 1

`endif

/* design/bus_map_pkg.sv */
`include "fpga_defs.svh"

package bus_map_pkg;

  // Decoded from CPU address bits 16:15
  typedef enum logic [1:0] {
    SEL_CONTROLLER = 2'b00,
    SEL_MOD        = 2'b01,
    SEL_STM        = 2'b10,
    SEL_RESERVED   = 2'b11
  } bram_select_t;

  // Controller register map, word addresses
  typedef enum logic [`BUS_ADDR_BITS-1:0] {
    ADDR_MOD_MEM_WR_SEGMENT = 'h0020,
    ADDR_STM_MEM_WR_SEGMENT = 'h0021,
    ADDR_STM_MEM_WR_PAGE    = 'h0022,
    ADDR_MOD_REQ_RD_SEGMENT = 'h0030,
    ADDR_MOD_CYCLE          = 'h0031,
    ADDR_MOD_FREQ_DIV       = 'h0032
  } ctl_addr_t;

endpackage

/* design/settings_pkg.sv */
`include "fpga_defs.svh"

package settings_pkg;

  // Playback settings for the modulation sampler
  typedef struct packed {
    logic                      req_rd_segment;
    logic [`MOD_IDX_BITS-1:0]  cycle;     // Last sample index
    logic [`FREQ_DIV_BITS-1:0] freq_div;  // Clocks per sample, never 0
  } mod_settings_t;

endpackage

/* design/memory_bus_if.sv */
`include "fpga_defs.svh"

interface memory_bus_if;

  logic                      en;
  logic                      we;
  bus_map_pkg::bram_select_t bram_select;
  logic [`BUS_ADDR_BITS-1:0] bram_addr;
  logic [`BUS_DATA_BITS-1:0] data_in;

  modport host(output en, output we, output bram_select, output bram_addr, output data_in);

  // Each client checks bram_select against its own select
  modport client(input en, input we, input bram_select, input bram_addr, input data_in);

endinterface

/* design/controller.sv */
`include "fpga_defs.svh"

module controller (
  input  logic                          CPU_CKIO,
  input  logic                          arst_n,
  memory_bus_if.client                  bus,
  output logic                          mod_wr_segment,
  output logic                          stm_wr_segment,
  output logic [`STM_PAGE_BITS-1:0]     stm_wr_page,
  output settings_pkg::mod_settings_t   mod_settings
);

  logic                      ctl_wr;
  bus_map_pkg::ctl_addr_t    ctl_addr;
  logic [`FREQ_DIV_BITS-1:0] freq_div_wr;

  assign ctl_wr = bus.en & bus.we & (bus.bram_select == bus_map_pkg::SEL_CONTROLLER);
  assign ctl_addr = bus_map_pkg::ctl_addr_t'(bus.bram_addr);

  // A divider of 0 would stall playback, treat it as 1
  assign freq_div_wr = (bus.data_in[`FREQ_DIV_BITS-1:0] == '0) ?
                       `FREQ_DIV_BITS'(1) : bus.data_in[`FREQ_DIV_BITS-1:0];

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      mod_wr_segment              <= 1'b0;
      stm_wr_segment              <= 1'b0;
      stm_wr_page                 <= '0;
      mod_settings.req_rd_segment <= 1'b0;
      mod_settings.cycle          <= `MOD_IDX_BITS'(`MOD_CYCLE_DEFAULT);
      mod_settings.freq_div       <= `FREQ_DIV_BITS'(`MOD_FREQ_DIV_DEFAULT);
    end else if (ctl_wr) begin
      case (ctl_addr)
        bus_map_pkg::ADDR_MOD_MEM_WR_SEGMENT: begin
          mod_wr_segment <= bus.data_in[0];
        end
        bus_map_pkg::ADDR_STM_MEM_WR_SEGMENT: begin
          stm_wr_segment <= bus.data_in[0];
        end
        bus_map_pkg::ADDR_STM_MEM_WR_PAGE: begin
          stm_wr_page <= bus.data_in[`STM_PAGE_BITS-1:0];
        end
        bus_map_pkg::ADDR_MOD_REQ_RD_SEGMENT: begin
          mod_settings.req_rd_segment <= bus.data_in[0];  // Taken by sampler at wrap
        end
        bus_map_pkg::ADDR_MOD_CYCLE: begin
          mod_settings.cycle <= bus.data_in[`MOD_IDX_BITS-1:0];
        end
        bus_map_pkg::ADDR_MOD_FREQ_DIV: begin
          mod_settings.freq_div <= freq_div_wr;
        end
        default: begin
          // Unmapped register, write dropped
        end
      endcase
    end
  end

endmodule

/* design/mod_memory.sv */
`include "fpga_defs.svh"

module mod_memory (
  input  logic                         CPU_CKIO,
  memory_bus_if.client                 bus,
  input  logic                         mod_wr_segment,
  input  logic                         rd_segment,
  input  logic [`MOD_IDX_BITS-1:0]     rd_idx,
  output logic [`MOD_SAMPLE_BITS-1:0]  rd_sample
);

  localparam int mem_words = 2 ** (`MOD_ADDR_BITS + 1);  // Both segments

  // Starts zeroed so playback reads 0 before any upload
  logic [`BUS_DATA_BITS-1:0] mem[mem_words] = '{default: '0};
  logic [`BUS_DATA_BITS-1:0] rd_word;
  logic                      rd_hi;
  logic                      wr_en;

  assign wr_en = bus.en & bus.we & (bus.bram_select == bus_map_pkg::SEL_MOD);

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[{mod_wr_segment, bus.bram_addr[`MOD_ADDR_BITS-1:0]}] <= bus.data_in;
    end
  end

  // Word read, byte picked by index LSB
  always_ff @(posedge CPU_CKIO) begin
    rd_word <= mem[{rd_segment, rd_idx[`MOD_IDX_BITS-1:1]}];
    rd_hi   <= rd_idx[0];
  end

  assign rd_sample = rd_hi ? rd_word[`BUS_DATA_BITS-1 -: `MOD_SAMPLE_BITS]
                           : rd_word[`MOD_SAMPLE_BITS-1:0];

endmodule

/* design/stm_memory.sv */
`include "fpga_defs.svh"

module stm_memory (
  input  logic                                      CPU_CKIO,
  memory_bus_if.client                              bus,
  input  logic                                      stm_wr_segment,
  input  logic [`STM_PAGE_BITS-1:0]                 stm_wr_page,
  input  logic                                      rd_segment,
  input  logic [`STM_PAGE_BITS+`STM_ADDR_BITS-1:0]  rd_addr,
  output logic [`BUS_DATA_BITS-1:0]                 rd_data
);

  localparam int mem_words = 2 ** (1 + `STM_PAGE_BITS + `STM_ADDR_BITS);

  logic [`BUS_DATA_BITS-1:0]                mem[mem_words];
  logic [`STM_PAGE_BITS+`STM_ADDR_BITS:0]   wr_addr;
  logic                                     wr_en;

  assign wr_en = bus.en & bus.we & (bus.bram_select == bus_map_pkg::SEL_STM);

  // Page comes from the controller, bus bits above the page are ignored
  assign wr_addr = {stm_wr_segment, stm_wr_page, bus.bram_addr[`STM_ADDR_BITS-1:0]};

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[wr_addr] <= bus.data_in;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_data <= mem[{rd_segment, rd_addr}];  // One cycle latency
  end

endmodule

/* design/mod_sampler.sv */
`include "fpga_defs.svh"

module mod_sampler (
  input  logic                         CPU_CKIO,
  input  logic                         arst_n,
  input  settings_pkg::mod_settings_t  mod_settings,
  input  logic [`MOD_SAMPLE_BITS-1:0]  rd_sample,
  output logic                         rd_segment,
  output logic [`MOD_IDX_BITS-1:0]     rd_idx,
  output logic [`MOD_SAMPLE_BITS-1:0]  mod_value,
  output logic [`MOD_IDX_BITS-1:0]     mod_idx,
  output logic                         mod_segment
);

  logic [`FREQ_DIV_BITS-1:0] tick_cnt;
  logic                      step;

  // Compare with >= so a smaller divider written mid-count takes effect at once
  assign step = (tick_cnt >= mod_settings.freq_div - `FREQ_DIV_BITS'(1));

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt   <= '0;
      rd_idx     <= '0;
      rd_segment <= 1'b0;
    end else if (step) begin
      tick_cnt <= '0;
      if (rd_idx >= mod_settings.cycle) begin
        rd_idx     <= '0;
        rd_segment <= mod_settings.req_rd_segment;  // Switch only at cycle end
      end else begin
        rd_idx <= rd_idx + 1'b1;
      end
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // Match the memory read latency
  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      mod_idx     <= '0;
      mod_segment <= 1'b0;
    end else begin
      mod_idx     <= rd_idx;
      mod_segment <= rd_segment;
    end
  end

  assign mod_value = rd_sample;  // Already one cycle behind rd_idx

endmodule

/* design/memory_top.sv */
`include "fpga_defs.svh"

module memory_top (
  input  logic                                      CPU_CKIO,
  input  logic                                      arst_n,
  input  logic                                      cpu_cs1_n,
  input  logic                                      cpu_we0_n,
  input  logic [`CPU_ADDR_BITS-1:0]                 cpu_addr,
  input  logic [`BUS_DATA_BITS-1:0]                 cpu_data,
  input  logic                                      stm_rd_segment,
  input  logic [`STM_PAGE_BITS+`STM_ADDR_BITS-1:0]  stm_rd_addr,
  output logic [`BUS_DATA_BITS-1:0]                 stm_rd_data,
  output logic [`MOD_SAMPLE_BITS-1:0]               mod_value,
  output logic [`MOD_IDX_BITS-1:0]                  mod_idx,
  output logic                                      mod_segment
);

  logic                         mod_wr_segment;
  logic                         stm_wr_segment;
  logic [`STM_PAGE_BITS-1:0]    stm_wr_page;
  settings_pkg::mod_settings_t  mod_settings;
  logic                         rd_segment;
  logic [`MOD_IDX_BITS-1:0]     rd_idx;
  logic [`MOD_SAMPLE_BITS-1:0]  rd_sample;

  memory_bus_if bus ();

  // Bit 0 of the byte address is dropped, bus is word addressed
  assign bus.en          = ~cpu_cs1_n;
  assign bus.we          = ~cpu_we0_n;
  assign bus.bram_select = bus_map_pkg::bram_select_t'(cpu_addr[`CPU_ADDR_BITS-1 -: 2]);
  assign bus.bram_addr   = cpu_addr[`BUS_ADDR_BITS:1];
  assign bus.data_in     = cpu_data;

  controller u_controller (
    .CPU_CKIO       (CPU_CKIO),
    .arst_n         (arst_n),
    .bus            (bus.client),
    .mod_wr_segment (mod_wr_segment),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page),
    .mod_settings   (mod_settings)
  );

  mod_memory u_mod_memory (
    .CPU_CKIO       (CPU_CKIO),
    .bus            (bus.client),
    .mod_wr_segment (mod_wr_segment),
    .rd_segment     (rd_segment),
    .rd_idx         (rd_idx),
    .rd_sample      (rd_sample)
  );

  stm_memory u_stm_memory (
    .CPU_CKIO       (CPU_CKIO),
    .bus            (bus.client),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page),
    .rd_segment     (stm_rd_segment),
    .rd_addr        (stm_rd_addr),
    .rd_data        (stm_rd_data)
  );

  mod_sampler u_mod_sampler (
    .CPU_CKIO     (CPU_CKIO),
    .arst_n       (arst_n),
    .mod_settings (mod_settings),
    .rd_sample    (rd_sample),
    .rd_segment   (rd_segment),
    .rd_idx       (rd_idx),
    .mod_value    (mod_value),
    .mod_idx      (mod_idx),
    .mod_segment  (mod_segment)
  );

endmodule

/* test/cpu_bus_bfm.sv */
`include "fpga_defs.svh"

module cpu_bus_bfm (
  input  logic                       CPU_CKIO,
  output logic                       cpu_cs1_n,
  output logic                       cpu_we0_n,
  output logic [`CPU_ADDR_BITS-1:0]  cpu_addr,
  output logic [`BUS_DATA_BITS-1:0]  cpu_data
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    cpu_cs1_n = 1'b1;
    cpu_we0_n = 1'b1;
    cpu_addr  = '0;
    cpu_data  = '0;
  end

  // Pins move 1 ns after the clock, we is low across two edges
  task automatic write_word(input bus_map_pkg::bram_select_t sel,
                            input logic [`BUS_ADDR_BITS-1:0] addr,
                            input logic [`BUS_DATA_BITS-1:0] data);
    @(posedge CPU_CKIO);
    #1;
    cpu_addr  = {sel, addr, 1'b0};  // Byte address
    cpu_data  = data;
    cpu_cs1_n = 1'b0;
    @(posedge CPU_CKIO);
    #1;
    cpu_we0_n = 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    #1;
    cpu_we0_n = 1'b1;
    cpu_cs1_n = 1'b1;
  endtask

  task automatic write_reg(input bus_map_pkg::ctl_addr_t addr,
                           input logic [`BUS_DATA_BITS-1:0] value);
    write_word(bus_map_pkg::SEL_CONTROLLER, addr, value);
  endtask

  // Low byte is the even sample
  task automatic write_mod(input logic seg, input logic [`MOD_ADDR_BITS-1:0] addr,
                           input logic [`BUS_DATA_BITS-1:0] samples);
    write_reg(bus_map_pkg::ADDR_MOD_MEM_WR_SEGMENT, `BUS_DATA_BITS'(seg));
    write_word(bus_map_pkg::SEL_MOD, `BUS_ADDR_BITS'(addr), samples);
  endtask

  task automatic write_stm(input logic seg, input logic [`STM_PAGE_BITS-1:0] page,
                           input logic [`BUS_ADDR_BITS-1:0] addr,
                           input logic [`BUS_DATA_BITS-1:0] word);
    write_reg(bus_map_pkg::ADDR_STM_MEM_WR_SEGMENT, `BUS_DATA_BITS'(seg));
    write_reg(bus_map_pkg::ADDR_STM_MEM_WR_PAGE, `BUS_DATA_BITS'(page));
    write_word(bus_map_pkg::SEL_STM, addr, word);
  endtask

endmodule

/* test/tb_memory_top.sv */
`include "fpga_defs.svh"

module tb_memory_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int stm_per_page = 8;
  localparam int mod_words = 8;
  localparam int bus_writes = 2 * 4 * stm_per_page * 3 + 2 * mod_words * 2 + 80;
  localparam int cycle_limit = bus_writes * 6 + 2000 + 1500;  // Writes, playback, margin

  logic                                      CPU_CKIO;
  logic                                      arst_n;
  logic                                      cpu_cs1_n;
  logic                                      cpu_we0_n;
  logic [`CPU_ADDR_BITS-1:0]                 cpu_addr;
  logic [`BUS_DATA_BITS-1:0]                 cpu_data;
  logic                                      stm_rd_segment;
  logic [`STM_PAGE_BITS+`STM_ADDR_BITS-1:0]  stm_rd_addr;
  logic [`BUS_DATA_BITS-1:0]                 stm_rd_data;
  logic [`MOD_SAMPLE_BITS-1:0]               mod_value;
  logic [`MOD_IDX_BITS-1:0]                  mod_idx;
  logic                                      mod_segment;

  // Reference model
  logic [`MOD_SAMPLE_BITS-1:0] mod_model[2][1024] = '{default: '0};
  logic [`BUS_DATA_BITS-1:0]   stm_model[2][4096];
  logic [12:0]                 stm_addrs[$];

  integer seed = 32'haa90_ab80;
  int     errors = 0;
  int     test_errors = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  int     cycles = 0;

  memory_top uut (
    .CPU_CKIO       (CPU_CKIO),
    .arst_n         (arst_n),
    .cpu_cs1_n      (cpu_cs1_n),
    .cpu_we0_n      (cpu_we0_n),
    .cpu_addr       (cpu_addr),
    .cpu_data       (cpu_data),
    .stm_rd_segment (stm_rd_segment),
    .stm_rd_addr    (stm_rd_addr),
    .stm_rd_data    (stm_rd_data),
    .mod_value      (mod_value),
    .mod_idx        (mod_idx),
    .mod_segment    (mod_segment)
  );

  cpu_bus_bfm bfm (
    .CPU_CKIO  (CPU_CKIO),
    .cpu_cs1_n (cpu_cs1_n),
    .cpu_we0_n (cpu_we0_n),
    .cpu_addr  (cpu_addr),
    .cpu_data  (cpu_data)
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #50 CPU_CKIO = ~CPU_CKIO;
  end

  always @(posedge CPU_CKIO) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run stopped after %0d clock cycles", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_sample(input string name);
    check_value({name, " sample"}, mod_model[mod_segment][mod_idx], mod_value);
  endtask

  task automatic report_test(input string name);
    if (errors == test_errors) begin
      tests_passed++;
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  // Address presented 1 ns after an edge and data sampled after the next edge
  task automatic stm_readback(input string name);
    logic [12:0] a;
    foreach (stm_addrs[i]) begin
      a = stm_addrs[i];
      @(posedge CPU_CKIO);
      #1;
      stm_rd_segment = a[12];
      stm_rd_addr    = a[11:0];
      @(posedge CPU_CKIO);
      @(negedge CPU_CKIO);
      check_value(name, stm_model[a[12]][a[11:0]], stm_rd_data);
    end
  endtask

  task automatic observe_playback(input string name, input int cyc, input int div,
                                  input int seg, input int n_cycles);
    int last;
    int hold;
    int n;
    bit found;
    n = 0;
    found = 1'b0;
    while (!found && n < 200 + 2 * (cyc + 1) * div) begin  // Wait for a wrap
      last = mod_idx;
      @(negedge CPU_CKIO);
      n++;
      found = (mod_idx == 0) && (last != 0);
    end
    if (!found) begin
      errors++;
      $display("%s: mod_idx never wrapped back to 0", name);
      return;
    end
    check_sample(name);
    hold = 1;
    last = 0;
    repeat (n_cycles * (cyc + 1) * div) begin
      @(negedge CPU_CKIO);
      check_sample(name);
      check_value({name, " segment"}, seg, mod_segment);
      if (mod_idx == last) begin
        hold++;
      end else begin
        check_value({name, " hold"}, div, hold);
        check_value({name, " next index"}, (last + 1) % (cyc + 1), mod_idx);
        hold = 1;
        last = mod_idx;
      end
    end
  endtask

  // Playback runs with cycle 15 and freq_div 3
  task automatic switch_segment(input int seg);
    int n;
    int last_idx;
    int last_seg;
    bfm.write_reg(bus_map_pkg::ADDR_MOD_REQ_RD_SEGMENT, 16'(seg));
    n = 0;
    while (mod_segment != seg && n < 16 * 3 + 4) begin
      last_idx = mod_idx;
      last_seg = mod_segment;
      @(negedge CPU_CKIO);
      n++;
      check_sample("segment switch");
      if (mod_segment != last_seg) begin
        check_value("switch at index", 0, mod_idx);
        check_value("switch after index", 15, last_idx);
      end
    end
    if (mod_segment != seg) begin
      errors++;
      $display("mod_segment did not change to %0d within one modulation cycle", seg);
    end
    observe_playback("after switch", 15, 3, seg, 1);
  endtask

  initial begin
    int addr;
    int word;
    int upper;
    int lo;
    int hi;
    int cyc;
    int div;
    int waited;
    bus_map_pkg::ctl_addr_t reg_addr;
    arst_n         = 1'b0;
    stm_rd_segment = 1'b0;
    stm_rd_addr    = '0;
    repeat (4) @(posedge CPU_CKIO);
    #1;
    arst_n = 1'b1;

    @(negedge CPU_CKIO);
    check_value("reset mod_value", 0, mod_value);
    check_value("reset mod_idx", 0, mod_idx);
    check_value("reset mod_segment", 0, mod_segment);
    waited = 1;
    while (mod_idx == 0 && waited < 100) begin
      @(negedge CPU_CKIO);
      waited++;
    end
    if (mod_idx == 0) begin
      errors++;
      $display("mod_idx never stepped after reset");
    end else begin
      check_value("reset first step", 1, mod_idx);
      if (waited < `MOD_FREQ_DIV_DEFAULT) begin
        errors++;
        $display("mod_idx stepped after only %0d cycles", waited);
      end
    end
    report_test("reset_state");

    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < 4; p++) begin
        repeat (stm_per_page) begin
          addr  = rand_below(1024);
          word  = rand_below(65536);
          upper = rand_below(16);  // Bits above the page field
          bfm.write_stm(s[0], p[1:0], {upper[3:0], addr[9:0]}, word[15:0]);
          stm_model[s][{p[1:0], addr[9:0]}] = word[15:0];
          stm_addrs.push_back({s[0], p[1:0], addr[9:0]});
        end
      end
    end
    stm_readback("stm readback");
    report_test("stm_write_read");

    for (int s = 0; s < 2; s++) begin
      for (int w = 0; w < mod_words; w++) begin
        lo = rand_below(256);
        hi = rand_below(256);
        mod_model[s][2 * w]     = lo[7:0];
        mod_model[s][2 * w + 1] = hi[7:0];
        bfm.write_mod(s[0], w[8:0], {hi[7:0], lo[7:0]});
      end
    end
    bfm.write_reg(bus_map_pkg::ADDR_MOD_CYCLE, 16'd15);
    bfm.write_reg(bus_map_pkg::ADDR_MOD_FREQ_DIV, 16'd3);
    observe_playback("mod packing", 15, 3, 0, 2);
    report_test("mod_packing");

    repeat (3) begin
      cyc = 1 + rand_below(12);
      div = 1 + rand_below(6);
      bfm.write_reg(bus_map_pkg::ADDR_MOD_CYCLE, 16'(cyc));
      bfm.write_reg(bus_map_pkg::ADDR_MOD_FREQ_DIV, 16'(div));
      observe_playback("index stepping", cyc, div, 0, 2);
    end
    report_test("index_stepping");

    bfm.write_reg(bus_map_pkg::ADDR_MOD_CYCLE, 16'd15);
    bfm.write_reg(bus_map_pkg::ADDR_MOD_FREQ_DIV, 16'd3);
    switch_segment(1);
    switch_segment(0);
    report_test("segment_transition");

    reg_addr = reg_addr.first();
    repeat (reg_addr.num()) begin
      bfm.write_word(bus_map_pkg::SEL_RESERVED, reg_addr, 16'(rand_below(65536)) | 16'h1);
      reg_addr = reg_addr.next();
    end
    // Reserved writes aimed at the words that playback and readback cover
    bfm.write_reg(bus_map_pkg::ADDR_MOD_MEM_WR_SEGMENT, 16'd0);
    for (int w = 0; w < mod_words; w++) begin
      bfm.write_word(bus_map_pkg::SEL_RESERVED, 14'(w),
                     ~{mod_model[0][2 * w + 1], mod_model[0][2 * w]});
    end
    foreach (stm_addrs[i]) begin
      if (stm_addrs[i][12:10] == 3'b111) begin  // Segment 1 page 3 still selected
        bfm.write_word(bus_map_pkg::SEL_RESERVED, 14'(stm_addrs[i][9:0]),
                       ~stm_model[1][stm_addrs[i][11:0]]);
      end
    end
    repeat (8) begin
      bfm.write_word(bus_map_pkg::SEL_CONTROLLER, 14'h3c00 | 14'(rand_below(1024)),
                     16'(rand_below(65536)) | 16'h1);  // Outside the register map
    end
    stm_readback("isolation stm");
    observe_playback("isolation mod", 15, 3, 0, 2);
    report_test("write_isolation");

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+design
design/bus_map_pkg.sv
design/settings_pkg.sv
design/memory_bus_if.sv
design/controller.sv
design/mod_memory.sv
design/stm_memory.sv
design/mod_sampler.sv
design/memory_top.sv
test/cpu_bus_bfm.sv
test/tb_memory_top.sv
